// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_pat_top
FLIST     ?= pat_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD       = 10,
	parameter int RESET_CYCLES = 5
)
(
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD/2) clk = ~clk;
	end

	// power-on reset, released just after an edge
	initial
	begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 reset = 1'b0;
	end

endmodule

// ==== bench/tb_pat_top.sv ====
`timescale 1ns/1ps

module tb_pat_top
	import pat_pkg::*;
();

	localparam int TEST_CYCLES = 400;             // all tests together rounded up
	localparam int MAX_CYCLES  = 5 * TEST_CYCLES; // watchdog limit
	localparam logic [19:0] NOP_W = 20'hFFFFF;    // same word decode holds in reset

	// reference alu codes, bench only
	localparam logic [3:0] F_OR   = 4'd0;
	localparam logic [3:0] F_AND  = 4'd1;
	localparam logic [3:0] F_NOT  = 4'd2;
	localparam logic [3:0] F_ADD  = 4'd3;
	localparam logic [3:0] F_SUB  = 4'd4;
	localparam logic [3:0] F_SHL  = 4'd5;
	localparam logic [3:0] F_SHLO = 4'd6;
	localparam logic [3:0] F_SHR  = 4'd7;
	localparam logic [3:0] F_ASR  = 4'd8;

	logic        clk, gen_rst, tst_rst, dut_rst;
	logic [19:0] i_instruction;
	logic [7:0]  i_field_in, i_inputs;
	logic [9:0]  o_pc;
	logic [4:0]  o_field_rd_ptr, o_field_wr_ptr;
	logic        o_field_wr_en;
	logic [7:0]  o_field_out, o_acc, o_outputs;

	logic [19:0] prog [1024];  // external program store
	logic [7:0]  field [32];   // field buffer
	int          cycles = 0;
	int          err_count = 0;

	// reference model state
	logic [7:0]  m_acc, m_out, m_fout;
	logic [7:0]  m_mem [32];
	logic [9:0]  m_pc;
	logic        m_wen;
	logic [4:0]  m_wptr;
	logic [19:0] p1, p2;       // in decode, in execute
	logic [7:0]  p1_mb, p2_mb; // data memory word seen at decode
	logic [19:0] drv_instr;
	logic [7:0]  drv_fin, drv_inp;

	assign dut_rst = gen_rst | tst_rst;

	tb_clock_gen #(.PERIOD(10), .RESET_CYCLES(5)) u_clk (.clk(clk), .reset(gen_rst));

	pat_top #(.DMEM_DEPTH(32)) DUT (
		.clk(clk), .reset(dut_rst), .i_instruction(i_instruction),
		.i_field_in(i_field_in), .i_inputs(i_inputs), .o_pc(o_pc),
		.o_field_rd_ptr(o_field_rd_ptr), .o_field_wr_ptr(o_field_wr_ptr),
		.o_field_wr_en(o_field_wr_en), .o_field_out(o_field_out),
		.o_acc(o_acc), .o_outputs(o_outputs)
	);

	// ==============================
	// instruction builders
	// ==============================
	function automatic logic [19:0] i8(input logic [4:0] fp, input logic [1:0] c,
		input logic f, input logic [3:0] op, input logic [7:0] imm);
		return {fp, c, f, op, imm};
	endfunction

	function automatic logic [19:0] i3(input logic [4:0] fp, input logic [1:0] c,
		input logic f, input logic [3:0] op3, input logic [2:0] k);
		return {fp, c, f, OP8_PREFIX, op3, 1'b0, k};
	endfunction

	function automatic logic [19:0] i0(input logic [3:0] op0);
		return {5'd0, 2'b10, 1'b0, OP8_PREFIX, OP3_PREFIX, op0};
	endfunction

	function automatic logic [7:0] ref_alu(input logic [3:0] fn, input logic [7:0] a,
		input logic [7:0] b);
		int s;
		s = int'(b[2:0]);
		case (fn)
			F_AND:   return a & b;
			F_NOT:   return ~a;
			F_ADD:   return a + b;
			F_SUB:   return a - b;
			F_SHL:   return a << s;
			F_SHLO:  return (a << s) | ~(8'hFF << s); // ones shifted in
			F_SHR:   return a >> s;
			F_ASR:   return 8'({{8{a[7]}}, a} >> s); // sign copies fill the top
			default: return a | b;
		endcase
	endfunction

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			err_count++;
			$display("[ERROR] %s got %h expected %h", name, got, exp);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	// ==============================
	// reference model for one commit
	// ==============================
	task automatic commit_model(input logic [19:0] w, input logic [7:0] mb,
		input logic [7:0] fin, input logic [7:0] inp);
		logic [3:0] op;
		logic       fop, ok, wr, pb, pin, st, ou, use_mb;
		logic [7:0] b, res;
		logic [3:0] fn;
		op = w[11:8];
		fop = w[12];
		ok = (w[14:13] == 2'b00) ? (m_acc == 8'h00) : (w[14:13] == 2'b01) ? m_acc[7] : 1'b1;
		{wr, pb, pin, st, ou, use_mb} = 6'b0;
		b = w[7:0];
		fn = F_OR;
		m_wen = 1'b0;
		if (op != 4'hF)
		begin
			case (op)
				4'h0: wr = 1'b1;
				4'h1: {wr, fn} = {1'b1, F_AND};
				4'h2: {wr, use_mb, fn} = {2'b11, F_ADD}; // addm
				4'h3: {wr, use_mb, fn} = {2'b11, F_SUB}; // subm
				4'h4: {wr, fn} = {1'b1, F_ADD};
				4'h5: {wr, fn} = {1'b1, F_SUB};
				4'h6: {wr, pb} = 2'b11;
				4'h7: {wr, pb, use_mb} = 3'b111;
				4'hB: st = 1'b1;
				4'hD: {wr, use_mb} = 2'b11;
				4'hE: {wr, use_mb, fn} = {2'b11, F_AND};
				default: ; // branches and spare codes change no state here
			endcase
			if (use_mb)
				b = mb;
		end
		else if (w[7:4] != 4'hF)
		begin
			b = {5'b0, w[2:0]};
			case (w[7:4])
				4'h0: {wr, fn} = {1'b1, F_SHL};
				4'h1: {wr, fn} = {1'b1, F_SHLO};
				4'h2: {wr, fn} = {1'b1, F_SHR};
				4'h3: {wr, fn} = {1'b1, F_ASR};
				4'h5: {wr, pin} = 2'b11;
				4'h8: ou = 1'b1;
				default: ;
			endcase
		end
		else if (w[3:0] == 4'h0)
			{wr, fn} = {1'b1, F_NOT};
		if (ok)
		begin
			if (wr)
			begin
				res = pb ? b : pin ? inp : ref_alu(fn, fop ? fin : m_acc, b);
				if (fop)
				begin
					m_wen = 1'b1;
					m_fout = res;
					m_wptr = w[19:15];
				end
				else
					m_acc = res;
			end
			if (st)
				m_mem[w[4:0]] = fop ? fin : m_acc; // address wraps on 32 words
			if (ou)
				m_out = m_acc;
		end
	endtask

	// one clock of model update, field buffer service, checks and drive
	task automatic advance_cycle();
		logic was_rst;
		@(posedge clk);
		was_rst = dut_rst; // reset level the DUT samples on this edge
		#1;
		if (was_rst)
		begin
			{m_acc, m_out, m_wen, m_pc} = '0;
			p1 = NOP_W;
			p2 = NOP_W;
		end
		else
		begin
			commit_model(p2, p2_mb, drv_fin, drv_inp);
			if (p1[11:8] == 4'h8)
				m_pc = m_pc + 10'(p1[7:0]);
			else if (p1[11:8] == 4'h9)
				m_pc = m_pc - 10'(p1[7:0]);
			else
				m_pc = m_pc + 10'd1;
			p2 = p1;
			p2_mb = p1_mb;
			p1 = drv_instr;
			p1_mb = m_mem[drv_instr[4:0]]; // read after this edge's store
		end
		if (o_field_wr_en)
			field[o_field_wr_ptr] = o_field_out;
		compare("o_pc", 32'(o_pc), 32'(m_pc));
		compare("o_acc", 32'(o_acc), 32'(m_acc));
		compare("o_outputs", 32'(o_outputs), 32'(m_out));
		compare("o_field_wr_en", 32'(o_field_wr_en), 32'(m_wen));
		if (m_wen)
		begin
			compare("o_field_out", 32'(o_field_out), 32'(m_fout));
			compare("o_field_wr_ptr", 32'(o_field_wr_ptr), 32'(m_wptr));
		end
		if (!was_rst)
			compare("o_field_rd_ptr", 32'(o_field_rd_ptr), 32'(p2[19:15]));
		drv_instr = prog[o_pc];
		drv_fin = field[o_field_rd_ptr];
		drv_inp = 8'($urandom);
		i_instruction = drv_instr;
		i_field_in = drv_fin;
		i_inputs = drv_inp;
	endtask

	task automatic run_steps(input int n);
		repeat (n) advance_cycle();
	endtask

	task automatic load_nops();
		foreach (prog[i]) prog[i] = NOP_W;
	endtask

	task automatic apply_reset();
		tst_rst = 1'b1;
		run_steps(3);
		tst_rst = 1'b0;
	endtask

	// ==============================
	// directed tests
	// ==============================
	task automatic reset_and_fetch();
		load_nops();
		apply_reset();
		compare("o_pc", 32'(o_pc), 32'h0);
		compare("o_field_wr_en", 32'(o_field_wr_en), 32'h0);
		compare("o_outputs", 32'(o_outputs), 32'h0);
		run_steps(12); // pc walks through the nops
	endtask

	task automatic acc_alu_ops();
		load_nops();
		prog[0] = i8(0, 2'b10, 0, OP8_LDI, 8'h5A);
		prog[1] = i8(0, 2'b10, 0, OP8_ADD, 8'h37);
		prog[2] = i8(0, 2'b10, 0, OP8_SUB, 8'h21);
		prog[3] = i8(0, 2'b10, 0, OP8_OR, 8'h81);
		prog[4] = i8(0, 2'b10, 0, OP8_AND, 8'hF3);
		prog[5] = i0(OP0_NOT);
		prog[6] = i3(0, 2'b10, 0, OP3_SHL, 3'd3);
		prog[7] = i3(0, 2'b10, 0, OP3_SHLO, 3'd2);
		prog[8] = i3(0, 2'b10, 0, OP3_SHR, 3'd1);
		prog[9] = i8(0, 2'b10, 0, OP8_LDI, 8'h96);
		prog[10] = i3(0, 2'b10, 0, OP3_ASR, 3'd2);
		apply_reset();
		run_steps(16);
		compare("o_acc", 32'(o_acc), 32'h0E5); // 0x96 asr 2
	endtask

	task automatic dmem_load_store();
		load_nops();
		prog[0] = i8(0, 2'b10, 0, OP8_LDI, 8'h05);
		prog[1] = i8(0, 2'b10, 0, OP8_STAM, 8'd3);
		prog[2] = i8(0, 2'b10, 0, OP8_LDI, 8'h09);
		prog[3] = i8(0, 2'b10, 0, OP8_STAM, 8'd3);
		prog[4] = i8(0, 2'b10, 0, OP8_LDM, 8'd3);  // right after store
		prog[6] = i8(0, 2'b10, 0, OP8_LDM, 8'd3);
		prog[7] = i8(0, 2'b10, 0, OP8_LDI, 8'h40);
		prog[8] = i8(0, 2'b10, 0, OP8_STAM, 8'd39); // wraps to word 7
		prog[10] = i8(0, 2'b10, 0, OP8_ADDM, 8'd3);
		prog[11] = i8(0, 2'b10, 0, OP8_SUBM, 8'd7);
		prog[12] = i8(0, 2'b10, 0, OP8_ORM, 8'd7);
		prog[13] = i8(0, 2'b10, 0, OP8_ANDM, 8'd3);
		prog[14] = i8(0, 2'b10, 0, OP8_LDM, 8'd7);
		apply_reset();
		run_steps(7);
		compare("o_acc", 32'(o_acc), 32'h05); // old word still read
		run_steps(14);
	endtask

	task automatic condition_codes();
		load_nops();
		prog[0] = i8(0, 2'b10, 0, OP8_LDI, 8'h00);
		prog[1] = i8(0, 2'b00, 0, OP8_LDI, 8'h07); // acc zero so it commits
		prog[2] = i8(0, 2'b00, 0, OP8_LDI, 8'h09); // suppressed
		prog[3] = i3(0, 2'b01, 0, OP3_OUT, 3'd0);  // acc positive so suppressed
		prog[4] = i8(0, 2'b10, 0, OP8_LDI, 8'h84);
		prog[5] = i8(0, 2'b00, 0, OP8_LDI, 8'h11);
		prog[6] = i3(0, 2'b01, 0, OP3_OUT, 3'd0);
		prog[7] = i8(0, 2'b01, 0, OP8_ADD, 8'h01);
		prog[8] = i3(0, 2'b11, 0, OP3_OUT, 3'd0);
		prog[9] = i8(0, 2'b01, 0, OP8_LDI, 8'h00);
		prog[10] = i3(0, 2'b00, 0, OP3_OUT, 3'd0);
		apply_reset();
		run_steps(16);
	endtask

	task automatic branch_targets();
		load_nops();
		prog[0] = i8(0, 2'b10, 0, OP8_LDI, 8'h01);
		prog[1] = i8(0, 2'b10, 0, OP8_BF, 8'd3);   // to 5
		prog[2] = i8(0, 2'b10, 0, OP8_ADD, 8'h02); // delay slot
		prog[3] = i8(0, 2'b10, 0, OP8_LDI, 8'h55);
		prog[4] = i8(0, 2'b10, 0, OP8_LDI, 8'h66);
		prog[5] = i8(0, 2'b10, 0, OP8_ADD, 8'h10);
		prog[6] = i8(0, 2'b10, 0, OP8_BB, 8'd5);   // back to 2
		prog[7] = i8(0, 2'b10, 0, OP8_ADD, 8'h40);
		apply_reset();
		run_steps(5);
		compare("o_acc", 32'(o_acc), 32'h03);
		run_steps(20);
	endtask

	task automatic field_and_io();
		load_nops();
		prog[0] = i8(5'd4, 2'b10, 1, OP8_LDI, 8'h3C);
		prog[1] = i8(5'd9, 2'b10, 1, OP8_ADD, 8'h05);
		prog[2] = i3(0, 2'b10, 0, OP3_IN, 3'd0);
		prog[3] = i3(5'd2, 2'b10, 1, OP3_IN, 3'd0);
		prog[4] = i3(0, 2'b10, 0, OP3_OUT, 3'd0);
		prog[6] = i8(5'd9, 2'b10, 1, OP8_STAM, 8'd10);
		prog[8] = i8(0, 2'b10, 0, OP8_LDM, 8'd10);
		apply_reset();
		run_steps(16);
	endtask

	// ==============================
	// main sequence and watchdog
	// ==============================
	initial
	begin
		int seed_val;
		tst_rst = 1'b0;
		i_instruction = NOP_W;
		i_field_in = 8'h00;
		i_inputs = 8'h00;
		drv_instr = NOP_W;
		drv_fin = 8'h00;
		drv_inp = 8'h00;
		load_nops();
		seed_val = $urandom(78865);
		foreach (field[i]) field[i] = 8'($urandom);
		while (gen_rst !== 1'b0)
			advance_cycle();
		reset_and_fetch();
		acc_alu_ops();
		dmem_load_store();
		condition_codes();
		branch_targets();
		field_and_io();
		if (err_count == 0)
		begin
			$display("TEST PASSED");
			$finish;
		end
		else
		begin
			$display("TEST FAILED");
			$fatal(1);
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= MAX_CYCLES)
		begin
			$display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
			$display("TEST FAILED");
			$fatal(1);
		end
	end

endmodule

// ==== pat_top.f ====
src/pat_pkg.sv
src/pat_exec_if.sv
src/pat_pc.sv
src/pat_decode.sv
src/pat_dmem.sv
src/pat_alu.sv
src/pat_execute.sv
src/pat_top.sv
bench/tb_clock_gen.sv
bench/tb_pat_top.sv

// ==== src/pat_alu.sv ====
`timescale 1ns/1ps

module pat_alu
	import pat_pkg::*;
(
	input  logic [D_WIDTH-1:0]      i_a,
	input  logic [D_WIDTH-1:0]      i_b,
	input  logic [ALU_FN_WIDTH-1:0] i_fn,
	output logic [D_WIDTH-1:0]      o_y
);

	logic [2:0]         sh; // shift distance
	logic [D_WIDTH-1:0] shlo_y;

	assign sh = i_b[2:0];

	// shift the inverse in so the vacated low bits come back as ones
	assign shlo_y = ~((~i_a) << sh);

	always_comb
	begin
		case (i_fn)
			ALU_OR:   o_y = i_a | i_b;
			ALU_AND:  o_y = i_a & i_b;
			ALU_NOT:  o_y = ~i_a;       // b ignored
			ALU_ADD:  o_y = i_a + i_b;  // wraps mod 256
			ALU_SUB:  o_y = i_a - i_b;
			ALU_SHL:  o_y = i_a << sh;
			ALU_SHLO: o_y = shlo_y;
			ALU_SHR:  o_y = i_a >> sh;
			ALU_ASR:  o_y = D_WIDTH'($signed(i_a) >>> sh); // sign kept
			default:  o_y = i_a;        // unused codes pass a
		endcase
	end

endmodule

// ==== src/pat_decode.sv ====
`timescale 1ns/1ps

module pat_decode
	import pat_pkg::*;
(
	input  logic                   clk,
	input  logic                   reset,
	input  logic [I_WIDTH-1:0]     i_instruction,
	output logic [D_ADR_WIDTH-1:0] o_dmem_rd_adr,
	input  logic [D_WIDTH-1:0]     i_dmem_rd_data,
	output logic                   o_branch_fwd,
	output logic                   o_branch_bwd,
	output logic [D_WIDTH-1:0]     o_branch_off,
	output logic [FP_WIDTH-1:0]    o_field_rd_ptr,
	pat_exec_if.decode             ex
);

	instr_u                  instr_q; // fetched word
	logic                    t_i8, t_i3;
	logic                    reg_op;   // writes acc or field
	logic                    src_mem;  // operand b from dmem
	logic                    pass_b, pass_in, store, out;
	logic [ALU_FN_WIDTH-1:0] alu_fn;
	logic [D_WIDTH-1:0]      imm;

	// ==============================
	// fetch register
	// ==============================
	always_ff @(posedge clk)
	begin
		if (reset)
			instr_q <= '1; // all ones decodes as i0 nop
		else
			instr_q <= i_instruction;
	end

	// prefix chain picks the view
	assign t_i8 = (instr_q.l.opcode != OP8_PREFIX);
	assign t_i3 = !t_i8 && (instr_q.s.op3 != OP3_PREFIX);
	assign imm  = t_i8 ? instr_q.l.imm : {5'b0, instr_q.s.low[2:0]};

	always_comb
	begin
		reg_op       = 1'b0;
		src_mem      = 1'b0;
		pass_b       = 1'b0;
		pass_in      = 1'b0;
		store        = 1'b0;
		out          = 1'b0;
		o_branch_fwd = 1'b0;
		o_branch_bwd = 1'b0;
		alu_fn       = ALU_OR;
		if (t_i8)
		begin
			case (instr_q.l.opcode)
				OP8_OR:   reg_op = 1'b1;
				OP8_AND:  begin reg_op = 1'b1; alu_fn = ALU_AND; end
				OP8_ADD:  begin reg_op = 1'b1; alu_fn = ALU_ADD; end
				OP8_SUB:  begin reg_op = 1'b1; alu_fn = ALU_SUB; end
				OP8_ADDM: begin reg_op = 1'b1; src_mem = 1'b1; alu_fn = ALU_ADD; end
				OP8_SUBM: begin reg_op = 1'b1; src_mem = 1'b1; alu_fn = ALU_SUB; end
				OP8_ORM:  begin reg_op = 1'b1; src_mem = 1'b1; end
				OP8_ANDM: begin reg_op = 1'b1; src_mem = 1'b1; alu_fn = ALU_AND; end
				OP8_LDI:  begin reg_op = 1'b1; pass_b = 1'b1; end
				OP8_LDM:  begin reg_op = 1'b1; pass_b = 1'b1; src_mem = 1'b1; end
				OP8_STAM: store = 1'b1;
				OP8_BF:   o_branch_fwd = 1'b1; // unconditional
				OP8_BB:   o_branch_bwd = 1'b1;
				default:  ; // A, C run as nop
			endcase
		end
		else if (t_i3)
		begin
			case (instr_q.s.op3)
				OP3_SHL:  begin reg_op = 1'b1; alu_fn = ALU_SHL; end
				OP3_SHLO: begin reg_op = 1'b1; alu_fn = ALU_SHLO; end
				OP3_SHR:  begin reg_op = 1'b1; alu_fn = ALU_SHR; end
				OP3_ASR:  begin reg_op = 1'b1; alu_fn = ALU_ASR; end
				OP3_IN:   begin reg_op = 1'b1; pass_in = 1'b1; end
				OP3_OUT:  out = 1'b1;
				default:  ;
			endcase
		end
		else
		begin
			case (instr_q.s.low)
				OP0_NOT: begin reg_op = 1'b1; alu_fn = ALU_NOT; end
				OP0_NOP: ; // nothing to do
				default: ;
			endcase
		end
	end

	assign o_dmem_rd_adr  = instr_q.l.imm; // read every cycle, used on src_mem
	assign o_branch_off   = instr_q.l.imm;
	assign o_field_rd_ptr = ex.field_ptr; // one edge after fetch

	// ==============================
	// stage register into execute
	// ==============================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ex.dest_acc   <= 1'b0;
			ex.dest_field <= 1'b0;
			ex.dest_mem   <= 1'b0;
			ex.do_out     <= 1'b0;
		end
		else
		begin
			ex.dest_acc   <= reg_op && !instr_q.l.field_op;
			ex.dest_field <= reg_op && instr_q.l.field_op;
			ex.dest_mem   <= store;
			ex.do_out     <= out;
		end
	end

	// payload only, qualified by the flags above
	always_ff @(posedge clk)
	begin
		ex.alu_fn      <= alu_fn;
		ex.operand_b   <= src_mem ? i_dmem_rd_data : imm;
		ex.pass_b      <= pass_b;
		ex.pass_in     <= pass_in;
		ex.cond        <= instr_q.l.cond;
		ex.mem_wr_adr  <= instr_q.l.imm;
		ex.store_field <= instr_q.l.field_op;
		ex.field_ptr   <= instr_q.l.field_ptr;
	end

endmodule

// ==== src/pat_dmem.sv ====
`timescale 1ns/1ps

module pat_dmem
	import pat_pkg::*;
#(
	parameter int DEPTH = 32
)
(
	input  logic                   clk,
	input  logic [D_ADR_WIDTH-1:0] i_rd_adr,
	output logic [D_WIDTH-1:0]     o_rd_data,
	input  logic                   i_wr_en,
	input  logic [D_ADR_WIDTH-1:0] i_wr_adr,
	input  logic [D_WIDTH-1:0]     i_wr_data
);

	logic [D_WIDTH-1:0] mem [DEPTH];

	// address wraps on the depth
	assign o_rd_data = mem[i_rd_adr % DEPTH]; // same cycle read

	always_ff @(posedge clk)
	begin
		if (i_wr_en)
			mem[i_wr_adr % DEPTH] <= i_wr_data; // visible from next cycle
	end

endmodule

// ==== src/pat_exec_if.sv ====
`timescale 1ns/1ps

// decoded instruction, registered in decode and consumed by execute
interface pat_exec_if
	import pat_pkg::*;
();

	logic                    dest_acc;    // result goes to acc
	logic                    dest_field;  // result goes to field buffer
	logic                    dest_mem;    // stam
	logic                    do_out;      // acc to outputs
	logic [ALU_FN_WIDTH-1:0] alu_fn;
	logic [D_WIDTH-1:0]      operand_b;   // dmem word or immediate
	logic                    pass_b;      // ldi, ldm
	logic                    pass_in;     // in
	logic [1:0]              cond;
	logic [D_ADR_WIDTH-1:0]  mem_wr_adr;
	logic                    store_field; // stam takes field_in instead of acc
	logic [FP_WIDTH-1:0]     field_ptr;

	modport decode (
		output dest_acc, dest_field, dest_mem, do_out, alu_fn, operand_b,
		output pass_b, pass_in, cond, mem_wr_adr, store_field, field_ptr
	);

	modport execute (
		input dest_acc, dest_field, dest_mem, do_out, alu_fn, operand_b,
		input pass_b, pass_in, cond, mem_wr_adr, store_field, field_ptr
	);

endinterface

// ==== src/pat_execute.sv ====
`timescale 1ns/1ps

module pat_execute
	import pat_pkg::*;
(
	input  logic                   clk,
	input  logic                   reset,
	pat_exec_if.execute            ex,
	input  logic [D_WIDTH-1:0]     i_inputs,
	input  logic [D_WIDTH-1:0]     i_field_in,
	output logic                   o_dmem_wr_en,
	output logic [D_ADR_WIDTH-1:0] o_dmem_wr_adr,
	output logic [D_WIDTH-1:0]     o_dmem_wr_data,
	output logic [D_WIDTH-1:0]     o_acc,
	output logic [D_WIDTH-1:0]     o_outputs,
	output logic [D_WIDTH-1:0]     o_field_out,
	output logic [FP_WIDTH-1:0]    o_field_wr_ptr,
	output logic                   o_field_wr_en
);

	logic               cond_ok;
	logic [D_WIDTH-1:0] acc_alu_y, field_alu_y;
	logic [D_WIDTH-1:0] acc_result, field_result;

	// condition on acc as it stands before this commit
	always_comb
	begin
		case (ex.cond)
			COND_ZERO:     cond_ok = (o_acc == '0);
			COND_NEG:      cond_ok = o_acc[D_WIDTH-1];
			COND_ALWAYS_A: cond_ok = 1'b1;
			COND_ALWAYS_B: cond_ok = 1'b1;
		endcase
	end

	// ==============================
	// two alus, one per target
	// ==============================
	pat_alu u_acc_alu (
		.i_a  (o_acc),
		.i_b  (ex.operand_b),
		.i_fn (ex.alu_fn),
		.o_y  (acc_alu_y)
	);

	pat_alu u_field_alu (
		.i_a  (i_field_in), // field word arrives this cycle
		.i_b  (ex.operand_b),
		.i_fn (ex.alu_fn),
		.o_y  (field_alu_y)
	);

	assign acc_result   = ex.pass_b ? ex.operand_b : ex.pass_in ? i_inputs : acc_alu_y;
	assign field_result = ex.pass_b ? ex.operand_b : ex.pass_in ? i_inputs : field_alu_y;

	// store lands in dmem on the commit edge
	assign o_dmem_wr_en   = ex.dest_mem && cond_ok;
	assign o_dmem_wr_adr  = ex.mem_wr_adr;
	assign o_dmem_wr_data = ex.store_field ? i_field_in : o_acc;

	// ==============================
	// commit
	// ==============================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			o_acc         <= '0;
			o_outputs     <= '0;
			o_field_wr_en <= 1'b0;
		end
		else
		begin
			o_field_wr_en <= ex.dest_field && cond_ok; // single cycle strobe
			if (cond_ok && ex.dest_acc)
				o_acc <= acc_result;
			if (cond_ok && ex.do_out)
				o_outputs <= o_acc; // out latches acc before any update
		end
	end

	// field data and its pointer, held until the next field write
	always_ff @(posedge clk)
	begin
		if (ex.dest_field && cond_ok)
		begin
			o_field_out    <= field_result;
			o_field_wr_ptr <= ex.field_ptr;
		end
	end

endmodule

// ==== src/pat_pc.sv ====
`timescale 1ns/1ps

module pat_pc
	import pat_pkg::*;
(
	input  logic                   i_clk,
	input  logic                   i_reset,
	input  logic                   i_branch_fwd, // bf in decode
	input  logic                   i_branch_bwd, // bb in decode
	input  logic [D_WIDTH-1:0]     i_branch_off, // unsigned offset
	output logic [I_ADR_WIDTH-1:0] o_pc
);

	logic [I_ADR_WIDTH-1:0] off_ext;
	logic [I_ADR_WIDTH-1:0] pc_inc;
	logic [I_ADR_WIDTH-1:0] pc_add;
	logic [I_ADR_WIDTH-1:0] pc_sub;

	// offset is zero extended, direction comes from the opcode
	assign off_ext = {{(I_ADR_WIDTH-D_WIDTH){1'b0}}, i_branch_off};

	// o_pc already holds branch address + 1 when decode sees the branch
	assign pc_inc = o_pc + I_ADR_WIDTH'(1);
	assign pc_add = o_pc + off_ext;
	assign pc_sub = o_pc - off_ext;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_pc <= '0;
		else if (i_branch_fwd)
			o_pc <= pc_add;
		else if (i_branch_bwd)
			o_pc <= pc_sub;
		else
			o_pc <= pc_inc; // straight line
	end

endmodule

// ==== src/pat_pkg.sv ====
package pat_pkg;

	// ==============================
	// widths
	// ==============================
	localparam int I_WIDTH      = 20; // instruction word
	localparam int I_ADR_WIDTH  = 10; // program address
	localparam int D_WIDTH      = 8;  // data path and accumulator
	localparam int D_ADR_WIDTH  = 8;  // data address field
	localparam int FP_WIDTH     = 5;  // field buffer pointer
	localparam int ALU_FN_WIDTH = 4;  // nine alu functions need 4 bits

	// condition codes, checked against acc in execute
	localparam logic [1:0] COND_ZERO     = 2'b00; // acc == 0
	localparam logic [1:0] COND_NEG      = 2'b01; // acc msb set
	localparam logic [1:0] COND_ALWAYS_A = 2'b10;
	localparam logic [1:0] COND_ALWAYS_B = 2'b11;

	// ==============================
	// opcodes
	// ==============================
	// i8 space, A and C unassigned
	localparam logic [3:0] OP8_OR     = 4'h0;
	localparam logic [3:0] OP8_AND    = 4'h1;
	localparam logic [3:0] OP8_ADDM   = 4'h2;
	localparam logic [3:0] OP8_SUBM   = 4'h3;
	localparam logic [3:0] OP8_ADD    = 4'h4;
	localparam logic [3:0] OP8_SUB    = 4'h5;
	localparam logic [3:0] OP8_LDI    = 4'h6;
	localparam logic [3:0] OP8_LDM    = 4'h7;
	localparam logic [3:0] OP8_BF     = 4'h8;
	localparam logic [3:0] OP8_BB     = 4'h9;
	localparam logic [3:0] OP8_STAM   = 4'hB;
	localparam logic [3:0] OP8_ORM    = 4'hD;
	localparam logic [3:0] OP8_ANDM   = 4'hE;
	localparam logic [3:0] OP8_PREFIX = 4'hF; // escape to short format

	// i3 space
	localparam logic [3:0] OP3_SHL    = 4'h0;
	localparam logic [3:0] OP3_SHLO   = 4'h1;
	localparam logic [3:0] OP3_SHR    = 4'h2;
	localparam logic [3:0] OP3_ASR    = 4'h3;
	localparam logic [3:0] OP3_IN     = 4'h5;
	localparam logic [3:0] OP3_OUT    = 4'h8;
	localparam logic [3:0] OP3_PREFIX = 4'hF; // escape to i0

	// i0 space
	localparam logic [3:0] OP0_NOT = 4'h0;
	localparam logic [3:0] OP0_NOP = 4'hF;

	// alu function select
	localparam logic [ALU_FN_WIDTH-1:0] ALU_OR   = 4'd0;
	localparam logic [ALU_FN_WIDTH-1:0] ALU_AND  = 4'd1;
	localparam logic [ALU_FN_WIDTH-1:0] ALU_NOT  = 4'd2;
	localparam logic [ALU_FN_WIDTH-1:0] ALU_ADD  = 4'd3;
	localparam logic [ALU_FN_WIDTH-1:0] ALU_SUB  = 4'd4;
	localparam logic [ALU_FN_WIDTH-1:0] ALU_SHL  = 4'd5;
	localparam logic [ALU_FN_WIDTH-1:0] ALU_SHLO = 4'd6;
	localparam logic [ALU_FN_WIDTH-1:0] ALU_SHR  = 4'd7;
	localparam logic [ALU_FN_WIDTH-1:0] ALU_ASR  = 4'd8;

	// ==============================
	// instruction word, two views
	// ==============================
	typedef struct packed {
		logic [FP_WIDTH-1:0] field_ptr;
		logic [1:0]          cond;
		logic                field_op; // 1: field word is operand a and target
		logic [3:0]          opcode;
		logic [7:0]          imm;
	} instr_long_t;

	typedef struct packed {
		logic [FP_WIDTH-1:0] field_ptr;
		logic [1:0]          cond;
		logic                field_op;
		logic [3:0]          prefix; // OP8_PREFIX here
		logic [3:0]          op3;
		logic [3:0]          low;    // i0 opcode, low 3 bits are the i3 immediate
	} instr_short_t;

	typedef union packed {
		instr_long_t  l;
		instr_short_t s;
	} instr_u;

endpackage

// ==== src/pat_top.sv ====
`timescale 1ns/1ps

module pat_top
	import pat_pkg::*;
#(
	parameter int DMEM_DEPTH = 32
)
(
	input  logic                   clk,
	input  logic                   reset,
	input  logic [I_WIDTH-1:0]     i_instruction,
	input  logic [D_WIDTH-1:0]     i_field_in,
	input  logic [D_WIDTH-1:0]     i_inputs,
	output logic [I_ADR_WIDTH-1:0] o_pc,
	output logic [FP_WIDTH-1:0]    o_field_rd_ptr,
	output logic [FP_WIDTH-1:0]    o_field_wr_ptr,
	output logic                   o_field_wr_en,
	output logic [D_WIDTH-1:0]     o_field_out,
	output logic [D_WIDTH-1:0]     o_acc,
	output logic [D_WIDTH-1:0]     o_outputs
);

	logic                   branch_fwd, branch_bwd;
	logic [D_WIDTH-1:0]     branch_off;
	logic [D_ADR_WIDTH-1:0] dmem_rd_adr, dmem_wr_adr;
	logic [D_WIDTH-1:0]     dmem_rd_data, dmem_wr_data;
	logic                   dmem_wr_en;

	pat_exec_if u_ex_if (); // decode -> execute

	// ==============================
	// fetch and decode
	// ==============================
	pat_pc u_pc (
		.i_clk        (clk),
		.i_reset      (reset),
		.i_branch_fwd (branch_fwd),
		.i_branch_bwd (branch_bwd),
		.i_branch_off (branch_off),
		.o_pc         (o_pc)
	);

	pat_decode u_decode (
		.clk            (clk),
		.reset          (reset),
		.i_instruction  (i_instruction),
		.o_dmem_rd_adr  (dmem_rd_adr),
		.i_dmem_rd_data (dmem_rd_data),
		.o_branch_fwd   (branch_fwd),
		.o_branch_bwd   (branch_bwd),
		.o_branch_off   (branch_off),
		.o_field_rd_ptr (o_field_rd_ptr),
		.ex             (u_ex_if.decode)
	);

	pat_dmem #(
		.DEPTH (DMEM_DEPTH)
	) u_dmem (
		.clk       (clk),
		.i_rd_adr  (dmem_rd_adr),
		.o_rd_data (dmem_rd_data),
		.i_wr_en   (dmem_wr_en),
		.i_wr_adr  (dmem_wr_adr),
		.i_wr_data (dmem_wr_data)
	);

	// ==============================
	// execute and commit
	// ==============================
	pat_execute u_execute (
		.clk            (clk),
		.reset          (reset),
		.ex             (u_ex_if.execute),
		.i_inputs       (i_inputs),
		.i_field_in     (i_field_in),
		.o_dmem_wr_en   (dmem_wr_en),
		.o_dmem_wr_adr  (dmem_wr_adr),
		.o_dmem_wr_data (dmem_wr_data),
		.o_acc          (o_acc),
		.o_outputs      (o_outputs),
		.o_field_out    (o_field_out),
		.o_field_wr_ptr (o_field_wr_ptr),
		.o_field_wr_en  (o_field_wr_en)
	);

endmodule
